//--- verilog/snes_ctrl_pkg.sv
/*
 * snes control plane package
 * bridge register map, field widths, reset hold lengths and the
 * payload types shared by the control blocks and the testbench
 */
package snes_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // shared types
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;
  // dpad 3:0, face 7:4, triggers 13:8, select 14, start 15
  typedef logic [15:0] key_t;
  // lstick x in 7:0, lstick y in 15:8
  typedef logic [31:0] joy_t;
  typedef logic [7:0]  stick_axis_t;
  typedef logic [64:0] rtc_word_t;
  // bit 0 override, bit 1 pal when overriding
  typedef logic [1:0]  region_t;
  typedef logic [3:0]  size_code_t;

  //////////////////////////////////////////////////////////////////////
  // bridge register map
  //////////////////////////////////////////////////////////////////////

  localparam bridge_addr_t ADDR_DOWNLOAD      = 32'h0000_0000;
  localparam bridge_addr_t ADDR_ROM_SIZE      = 32'h0000_0004;
  localparam bridge_addr_t ADDR_ROM_TYPE      = 32'h0000_0008;
  localparam bridge_addr_t ADDR_RAM_SIZE      = 32'h0000_000C;
  localparam bridge_addr_t ADDR_PAL           = 32'h0000_0010;
  localparam bridge_addr_t ADDR_RESET         = 32'h0000_0050;
  localparam bridge_addr_t ADDR_CPU_TURBO     = 32'h0000_0080;
  localparam bridge_addr_t ADDR_GSU_TURBO     = 32'h0000_0084;
  localparam bridge_addr_t ADDR_MULTITAP      = 32'h0000_0100;
  localparam bridge_addr_t ADDR_LIGHTGUN      = 32'h0000_0104;
  localparam bridge_addr_t ADDR_AIM_SPEED     = 32'h0000_0108;
  localparam bridge_addr_t ADDR_DEADZONE      = 32'h0000_010C;
  localparam bridge_addr_t ADDR_SQUARE_PIXELS = 32'h0000_0200;
  localparam bridge_addr_t ADDR_BLEND         = 32'h0000_0204;
  localparam bridge_addr_t ADDR_REGION        = 32'h0000_0208;
  localparam bridge_addr_t ADDR_IGR           = 32'h0000_020C;

  // stick rest position
  localparam stick_axis_t STICK_CENTER = 8'd128;

  // reset stretch lengths in clk_74a cycles
  localparam int unsigned RESET_HOLD_CYCLES = 256;
  localparam int unsigned IGR_HOLD_CYCLES   = 64;
  localparam int unsigned HOLD_CNT_W        = 9;

  // data table entry for the save ram size
  localparam int unsigned DT_ADDR_W = 10;
  localparam int unsigned DT_DATA_W = 32;
  localparam logic [DT_DATA_W-1:0] SAVE_SIZE_BASE      = 32'd1024;
  localparam logic [DT_ADDR_W-1:0] SAVE_SIZE_SLOT_ADDR = 10'd3;

endpackage

//--- verilog/settings_regs.sv
/*
 * settings register bank
 * captures host bridge writes into the core settings, derives the
 * forced region and pulses the host reset command
 */
`timescale 1ns/1ps

module settings_regs (
  input  logic                        clk_74a,
  input  logic                        pll_core_locked,
  input  logic                        bridge_wr,
  input  snes_ctrl_pkg::bridge_addr_t bridge_addr,
  input  snes_ctrl_pkg::bridge_data_t bridge_wr_data,
  output logic                        ioctl_download,
  output snes_ctrl_pkg::size_code_t   rom_size,
  output snes_ctrl_pkg::size_code_t   ram_size,
  output logic [7:0]                  rom_type,
  output logic                        pal,
  output logic                        forced_pal,
  output logic                        cpu_turbo,
  output logic                        gsu_turbo,
  output logic                        multitap_enabled,
  output logic                        lightgun_enabled,
  output logic                        lightgun_type,
  output logic                        mouse_enabled,
  output logic [7:0]                  dpad_aim_speed,
  output logic [7:0]                  joystick_deadzone,
  output logic                        use_square_pixels,
  output logic                        blend_enabled,
  output snes_ctrl_pkg::region_t      core_region,
  output logic                        igr_enable,
  output snes_ctrl_pkg::key_t         igr_combo,
  output logic                        reset_cmd
);

  import snes_ctrl_pkg::*;

  logic    pal_d;
  region_t region_d;

  // next pal and region, so forced_pal lands on the same edge
  always_comb begin
    pal_d    = pal;
    region_d = core_region;
    if (bridge_wr && bridge_addr == ADDR_PAL) begin
      pal_d = bridge_wr_data[0];
    end
    if (bridge_wr && bridge_addr == ADDR_REGION) begin
      region_d = bridge_wr_data[1:0];
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ioctl_download    <= 1'b0;
      rom_size          <= '0;
      ram_size          <= '0;
      rom_type          <= '0;
      pal               <= 1'b0;
      forced_pal        <= 1'b0;
      cpu_turbo         <= 1'b0;
      gsu_turbo         <= 1'b0;
      multitap_enabled  <= 1'b0;
      lightgun_enabled  <= 1'b0;
      lightgun_type     <= 1'b0;
      mouse_enabled     <= 1'b0;
      dpad_aim_speed    <= '0;
      joystick_deadzone <= '0;
      use_square_pixels <= 1'b0;
      blend_enabled     <= 1'b0;
      core_region       <= '0;
      igr_enable        <= 1'b0;
      igr_combo         <= '0;
      reset_cmd         <= 1'b0;
    end else begin
      pal         <= pal_d;
      core_region <= region_d;
      forced_pal  <= region_d[0] ? region_d[1] : pal_d;
      // one cycle pulse per host reset write
      reset_cmd   <= bridge_wr && (bridge_addr == ADDR_RESET);
      if (bridge_wr) begin
        case (bridge_addr)
          ADDR_DOWNLOAD:      ioctl_download    <= bridge_wr_data[0];
          ADDR_ROM_SIZE:      rom_size          <= bridge_wr_data[3:0];
          ADDR_ROM_TYPE:      rom_type          <= bridge_wr_data[7:0];
          ADDR_RAM_SIZE:      ram_size          <= bridge_wr_data[3:0];
          ADDR_CPU_TURBO:     cpu_turbo         <= bridge_wr_data[0];
          ADDR_GSU_TURBO:     gsu_turbo         <= bridge_wr_data[0];
          ADDR_MULTITAP:      multitap_enabled  <= bridge_wr_data[0];
          ADDR_LIGHTGUN: begin
            lightgun_enabled <= bridge_wr_data[0];
            lightgun_type    <= bridge_wr_data[1];
            mouse_enabled    <= bridge_wr_data[2];
          end
          ADDR_AIM_SPEED:     dpad_aim_speed    <= bridge_wr_data[7:0];
          ADDR_DEADZONE:      joystick_deadzone <= bridge_wr_data[7:0];
          ADDR_SQUARE_PIXELS: use_square_pixels <= bridge_wr_data[0];
          ADDR_BLEND:         blend_enabled     <= bridge_wr_data[0];
          ADDR_IGR: begin
            igr_enable <= bridge_wr_data[16];
            igr_combo  <= bridge_wr_data[15:0];
          end
          // pal, region and reset handled above, others unmapped
          default: ;
        endcase
      end
    end
  end

endmodule

//--- verilog/core_reset_gen.sv
/*
 * core reset generator
 * one hold counter stretches the host reset command and the
 * player 1 in-game reset combo into the core reset
 */
`timescale 1ns/1ps

module core_reset_gen (
  input  logic                clk_74a,
  input  logic                pll_core_locked,
  input  logic                reset_cmd,
  input  logic                igr_enable,
  input  snes_ctrl_pkg::key_t igr_combo,
  input  snes_ctrl_pkg::key_t cont1_key,
  output logic                core_reset
);

  import snes_ctrl_pkg::*;

  logic [HOLD_CNT_W-1:0] hold_cnt;
  logic [HOLD_CNT_W-1:0] hold_nxt;
  logic                  combo_hit;

  assign combo_hit = igr_enable && (cont1_key == igr_combo);

  // host command first, then combo, else count down
  always_comb begin
    hold_nxt = hold_cnt;
    if (reset_cmd) begin
      hold_nxt = HOLD_CNT_W'(RESET_HOLD_CYCLES);
    end else if (combo_hit) begin
      hold_nxt = HOLD_CNT_W'(IGR_HOLD_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_nxt = hold_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt   <= '0;
      core_reset <= 1'b0;
    end else begin
      hold_cnt   <= hold_nxt;
      core_reset <= (hold_nxt != '0);
    end
  end

endmodule

//--- verilog/stick_deadzone.sv
/*
 * player 1 stick deadzone
 * recentres both axes while the summed deflection stays
 * inside the configured deadzone
 */
`timescale 1ns/1ps

module stick_deadzone (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  snes_ctrl_pkg::joy_t        cont1_joy,
  input  logic [7:0]                 joystick_deadzone,
  output snes_ctrl_pkg::stick_axis_t stick_x,
  output snes_ctrl_pkg::stick_axis_t stick_y
);

  import snes_ctrl_pkg::*;

  stick_axis_t raw_x;
  stick_axis_t raw_y;
  logic [8:0]  defl_sum;
  logic        outside;

  // distance from centre, max 128
  function automatic logic [7:0] deflect(input stick_axis_t axis);
    return axis[7] ? {1'b0, axis[6:0]} : STICK_CENTER - {1'b0, axis[6:0]};
  endfunction

  assign raw_x    = cont1_joy[7:0];
  assign raw_y    = cont1_joy[15:8];
  assign defl_sum = {1'b0, deflect(raw_x)} + {1'b0, deflect(raw_y)};
  assign outside  = defl_sum > {1'b0, joystick_deadzone};

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      stick_x <= STICK_CENTER;
      stick_y <= STICK_CENTER;
    end else begin
      stick_x <= outside ? raw_x : STICK_CENTER;
      stick_y <= outside ? raw_y : STICK_CENTER;
    end
  end

endmodule

//--- verilog/rtc_packer.sv
/*
 * rtc word packer
 * toggles a new-second flag on every change of the host time and
 * packs date and time into the emulator rtc word
 */
`timescale 1ns/1ps

module rtc_packer (
  input  logic                     clk_74a,
  input  logic                     pll_core_locked,
  input  logic [31:0]              rtc_date,
  input  logic [31:0]              rtc_time,
  output snes_ctrl_pkg::rtc_word_t rtc_word
);

  logic [31:0] prev_time;
  logic        time_changed;

  assign time_changed = (rtc_time != prev_time);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_time <= '0;
      rtc_word  <= '0;
    end else begin
      prev_time <= rtc_time;
      // flag, empty byte, weekday fixed at 1, yy mm dd, hh mm ss
      rtc_word  <= {
        rtc_word[64] ^ time_changed,
        8'h00,
        8'h01,
        rtc_date[23:0],
        rtc_time[23:0]
      };
    end
  end

endmodule

//--- verilog/save_slot_tracker.sv
/*
 * save slot tracker
 * holds the save-download window between a data slot request and
 * the completion edge, and keeps the save size table entry written
 */
`timescale 1ns/1ps

module save_slot_tracker (
  input  logic                                  clk_74a,
  input  logic                                  pll_core_locked,
  input  logic                                  dataslot_requestread,
  input  logic                                  dataslot_requestwrite,
  input  logic                                  dataslot_allcomplete,
  input  snes_ctrl_pkg::size_code_t             sram_size,
  output logic                                  save_download,
  output logic                                  datatable_wren,
  output logic [snes_ctrl_pkg::DT_ADDR_W-1:0]   datatable_addr,
  output logic [snes_ctrl_pkg::DT_DATA_W-1:0]   datatable_data
);

  import snes_ctrl_pkg::*;

  logic allcomplete_prev;
  logic allcomplete_rise;

  assign allcomplete_rise = dataslot_allcomplete && !allcomplete_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_prev <= 1'b0;
      save_download    <= 1'b0;
      datatable_wren   <= 1'b0;
      datatable_addr   <= '0;
      datatable_data   <= '0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;
      // a new request beats a completion in the same cycle
      if (dataslot_requestread || dataslot_requestwrite) begin
        save_download <= 1'b1;
      end else if (allcomplete_rise) begin
        save_download <= 1'b0;
      end
      datatable_wren <= 1'b1;
      datatable_addr <= SAVE_SIZE_SLOT_ADDR;
      // size code 0 means no save ram
      datatable_data <= (sram_size != '0) ? (SAVE_SIZE_BASE << sram_size) : '0;
    end
  end

endmodule

//--- verilog/snes_ctrl_top.sv
/*
 * snes control plane top
 * connects the settings bank, reset generator, stick deadzone,
 * rtc packer and save slot tracker
 */
`timescale 1ns/1ps

module snes_ctrl_top (
  input  logic                                clk_74a,
  input  logic                                pll_core_locked,
  // bridge
  input  logic                                bridge_wr,
  input  snes_ctrl_pkg::bridge_addr_t         bridge_addr,
  input  snes_ctrl_pkg::bridge_data_t         bridge_wr_data,
  // player 1
  input  snes_ctrl_pkg::key_t                 cont1_key,
  input  snes_ctrl_pkg::joy_t                 cont1_joy,
  // host command handler
  input  logic [31:0]                         rtc_date,
  input  logic [31:0]                         rtc_time,
  input  logic                                dataslot_requestread,
  input  logic                                dataslot_requestwrite,
  input  logic                                dataslot_allcomplete,
  input  snes_ctrl_pkg::size_code_t           sram_size,
  // settings
  output logic                                ioctl_download,
  output snes_ctrl_pkg::size_code_t           rom_size,
  output snes_ctrl_pkg::size_code_t           ram_size,
  output logic [7:0]                          rom_type,
  output logic                                pal,
  output logic                                forced_pal,
  output logic                                cpu_turbo,
  output logic                                gsu_turbo,
  output logic                                multitap_enabled,
  output logic                                lightgun_enabled,
  output logic                                lightgun_type,
  output logic                                mouse_enabled,
  output logic [7:0]                          dpad_aim_speed,
  output logic [7:0]                          joystick_deadzone,
  output logic                                use_square_pixels,
  output logic                                blend_enabled,
  output snes_ctrl_pkg::region_t              core_region,
  output logic                                igr_enable,
  output snes_ctrl_pkg::key_t                 igr_combo,
  // core side
  output logic                                core_reset,
  output snes_ctrl_pkg::stick_axis_t          stick_x,
  output snes_ctrl_pkg::stick_axis_t          stick_y,
  output snes_ctrl_pkg::rtc_word_t            rtc_word,
  output logic                                save_download,
  output logic                                datatable_wren,
  output logic [snes_ctrl_pkg::DT_ADDR_W-1:0] datatable_addr,
  output logic [snes_ctrl_pkg::DT_DATA_W-1:0] datatable_data
);

  logic reset_cmd;

  settings_regs u_settings_regs (
    .clk_74a           (clk_74a),
    .pll_core_locked   (pll_core_locked),
    .bridge_wr         (bridge_wr),
    .bridge_addr       (bridge_addr),
    .bridge_wr_data    (bridge_wr_data),
    .ioctl_download    (ioctl_download),
    .rom_size          (rom_size),
    .ram_size          (ram_size),
    .rom_type          (rom_type),
    .pal               (pal),
    .forced_pal        (forced_pal),
    .cpu_turbo         (cpu_turbo),
    .gsu_turbo         (gsu_turbo),
    .multitap_enabled  (multitap_enabled),
    .lightgun_enabled  (lightgun_enabled),
    .lightgun_type     (lightgun_type),
    .mouse_enabled     (mouse_enabled),
    .dpad_aim_speed    (dpad_aim_speed),
    .joystick_deadzone (joystick_deadzone),
    .use_square_pixels (use_square_pixels),
    .blend_enabled     (blend_enabled),
    .core_region       (core_region),
    .igr_enable        (igr_enable),
    .igr_combo         (igr_combo),
    .reset_cmd         (reset_cmd)
  );

  core_reset_gen u_core_reset_gen (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .reset_cmd       (reset_cmd),
    .igr_enable      (igr_enable),
    .igr_combo       (igr_combo),
    .cont1_key       (cont1_key),
    .core_reset      (core_reset)
  );

  stick_deadzone u_stick_deadzone (
    .clk_74a           (clk_74a),
    .pll_core_locked   (pll_core_locked),
    .cont1_joy         (cont1_joy),
    .joystick_deadzone (joystick_deadzone),
    .stick_x           (stick_x),
    .stick_y           (stick_y)
  );

  rtc_packer u_rtc_packer (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .rtc_date        (rtc_date),
    .rtc_time        (rtc_time),
    .rtc_word        (rtc_word)
  );

  save_slot_tracker u_save_slot_tracker (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .sram_size             (sram_size),
    .save_download         (save_download),
    .datatable_wren        (datatable_wren),
    .datatable_addr        (datatable_addr),
    .datatable_data        (datatable_data)
  );

endmodule

//--- dv/tb_snes_ctrl_checks.svh
/*
 * testbench compare tasks
 * one compare per result type, with shared error and check counters
 */
`ifndef TB_SNES_CTRL_CHECKS_SVH
`define TB_SNES_CTRL_CHECKS_SVH

int    error_count = 0;
int    check_count = 0;
string test_name   = "reset";

task automatic check_bit(input string what, input logic exp, input logic act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_key(input string what, input key_t exp, input key_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_axis(input string what, input stick_axis_t exp, input stick_axis_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_size(input string what, input size_code_t exp, input size_code_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
  end
endtask

task automatic check_rtc(input string what, input rtc_word_t exp, input rtc_word_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
  end
endtask

// wide values and narrow byte fields, zero extended by the caller
task automatic check_data(input string what, input bridge_data_t exp, input bridge_data_t act);
  check_count++;
  if (act !== exp) begin
    error_count++;
    $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
  end
endtask

`endif

//--- dv/tb_snes_ctrl.sv
/*
 * snes control plane testbench
 * random stimulus against a cycle model of the control blocks,
 * with a cycle limit on the whole run
 */
`timescale 1ns/1ps

module tb_snes_ctrl;

  import snes_ctrl_pkg::*;

  `include "tb_snes_ctrl_checks.svh"

  //////////////////////////////////////////////////////////////////////
  // run lengths
  //////////////////////////////////////////////////////////////////////

  localparam int SETTINGS_CYCLES = 400;
  localparam int RESET_TEST_CYCLES = IGR_HOLD_CYCLES + 2 * (RESET_HOLD_CYCLES + 40) + 110;
  localparam int IGR_OFF_CYCLES = 50;
  localparam int IGR_TEST_CYCLES = 60 + IGR_HOLD_CYCLES + 10 + IGR_OFF_CYCLES + 10;
  localparam int DZ_CYCLES = 400;
  localparam int RTC_CYCLES = 300;
  localparam int SAVE_CYCLES = 300;
  localparam int TIMEOUT_CYCLES = 2 * (16 + SETTINGS_CYCLES + RESET_TEST_CYCLES
                                  + IGR_TEST_CYCLES + DZ_CYCLES + RTC_CYCLES + SAVE_CYCLES);

  // every mapped setting address except the reset command
  localparam bridge_addr_t SETTING_ADDRS [15] = '{
    ADDR_DOWNLOAD, ADDR_ROM_SIZE, ADDR_ROM_TYPE, ADDR_RAM_SIZE, ADDR_PAL,
    ADDR_CPU_TURBO, ADDR_GSU_TURBO, ADDR_MULTITAP, ADDR_LIGHTGUN, ADDR_AIM_SPEED,
    ADDR_DEADZONE, ADDR_SQUARE_PIXELS, ADDR_BLEND, ADDR_REGION, ADDR_IGR
  };

  logic         clk_74a;
  logic         pll_core_locked;
  logic         bridge_wr;
  bridge_addr_t bridge_addr;
  bridge_data_t bridge_wr_data;
  key_t         cont1_key;
  joy_t         cont1_joy;
  logic [31:0]  rtc_date;
  logic [31:0]  rtc_time;
  logic         dataslot_requestread;
  logic         dataslot_requestwrite;
  logic         dataslot_allcomplete;
  size_code_t   sram_size;

  logic         ioctl_download;
  size_code_t   rom_size;
  size_code_t   ram_size;
  logic [7:0]   rom_type;
  logic         pal;
  logic         forced_pal;
  logic         cpu_turbo;
  logic         gsu_turbo;
  logic         multitap_enabled;
  logic         lightgun_enabled;
  logic         lightgun_type;
  logic         mouse_enabled;
  logic [7:0]   dpad_aim_speed;
  logic [7:0]   joystick_deadzone;
  logic         use_square_pixels;
  logic         blend_enabled;
  region_t      core_region;
  logic         igr_enable;
  key_t         igr_combo;
  logic         core_reset;
  stick_axis_t  stick_x;
  stick_axis_t  stick_y;
  rtc_word_t    rtc_word;
  logic         save_download;
  logic         datatable_wren;
  logic [9:0]   datatable_addr;
  logic [31:0]  datatable_data;

  // model state
  logic         m_download;
  size_code_t   m_rom_size;
  size_code_t   m_ram_size;
  logic [7:0]   m_rom_type;
  logic         m_pal;
  logic         m_forced_pal;
  logic         m_cpu_turbo;
  logic         m_gsu_turbo;
  logic         m_multitap;
  logic         m_lightgun;
  logic         m_lightgun_type;
  logic         m_mouse;
  logic [7:0]   m_aim_speed;
  logic [7:0]   m_deadzone;
  logic         m_square_pixels;
  logic         m_blend;
  region_t      m_region;
  logic         m_igr_enable;
  key_t         m_igr_combo;
  logic         m_reset_cmd;
  int           m_hold;
  logic         m_core_reset;
  stick_axis_t  m_stick_x;
  stick_axis_t  m_stick_y;
  logic         m_flag;
  logic [31:0]  m_prev_time;
  rtc_word_t    m_rtc;
  logic         m_save;
  logic         m_allc_prev;
  logic         m_dt_wren;
  logic [9:0]   m_dt_addr;
  logic [31:0]  m_dt_data;

  int           cycle_count = 0;

  snes_ctrl_top UUT (.*);

  initial begin
    clk_74a = 1'b0;
    forever #50 clk_74a = ~clk_74a;
  end

  always @(posedge clk_74a) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles in test %s", cycle_count, test_name);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // distance of one axis from the rest position
  function automatic int axis_offset(input stick_axis_t a);
    if (a >= STICK_CENTER) begin
      return int'(a) - int'(STICK_CENTER);
    end
    return int'(STICK_CENTER) - int'(a);
  endfunction

  task automatic clear_model();
    {m_download, m_pal, m_forced_pal, m_cpu_turbo, m_gsu_turbo} = '0;
    {m_multitap, m_lightgun, m_lightgun_type, m_mouse} = '0;
    {m_square_pixels, m_blend, m_igr_enable, m_reset_cmd, m_core_reset} = '0;
    m_rom_size = '0;
    m_ram_size = '0;
    m_rom_type = '0;
    m_aim_speed = '0;
    m_deadzone = '0;
    m_region = '0;
    m_igr_combo = '0;
    m_hold = 0;
    m_stick_x = STICK_CENTER;
    m_stick_y = STICK_CENTER;
    m_flag = 1'b0;
    m_prev_time = '0;
    m_rtc = '0;
    m_save = 1'b0;
    m_allc_prev = 1'b0;
    m_dt_wren = 1'b0;
    m_dt_addr = '0;
    m_dt_data = '0;
  endtask

  // one clock edge, using the inputs held during the cycle before it
  task automatic update_model();
    logic combo;
    int   dx;
    int   dy;
    // reset counter sees last cycle's command and igr settings
    combo = m_igr_enable && (cont1_key == m_igr_combo);
    if (m_reset_cmd) begin
      m_hold = RESET_HOLD_CYCLES;
    end else if (combo) begin
      m_hold = IGR_HOLD_CYCLES;
    end else if (m_hold > 0) begin
      m_hold--;
    end
    m_core_reset = (m_hold != 0);
    dx = axis_offset(cont1_joy[7:0]);
    dy = axis_offset(cont1_joy[15:8]);
    m_stick_x = (dx + dy > int'(m_deadzone)) ? cont1_joy[7:0] : STICK_CENTER;
    m_stick_y = (dx + dy > int'(m_deadzone)) ? cont1_joy[15:8] : STICK_CENTER;
    m_reset_cmd = bridge_wr && (bridge_addr == ADDR_RESET);
    if (bridge_wr) begin
      case (bridge_addr)
        ADDR_DOWNLOAD: m_download = bridge_wr_data[0];
        ADDR_ROM_SIZE: m_rom_size = bridge_wr_data[3:0];
        ADDR_ROM_TYPE: m_rom_type = bridge_wr_data[7:0];
        ADDR_RAM_SIZE: m_ram_size = bridge_wr_data[3:0];
        ADDR_PAL: m_pal = bridge_wr_data[0];
        ADDR_CPU_TURBO: m_cpu_turbo = bridge_wr_data[0];
        ADDR_GSU_TURBO: m_gsu_turbo = bridge_wr_data[0];
        ADDR_MULTITAP: m_multitap = bridge_wr_data[0];
        ADDR_LIGHTGUN: {m_mouse, m_lightgun_type, m_lightgun} = bridge_wr_data[2:0];
        ADDR_AIM_SPEED: m_aim_speed = bridge_wr_data[7:0];
        ADDR_DEADZONE: m_deadzone = bridge_wr_data[7:0];
        ADDR_SQUARE_PIXELS: m_square_pixels = bridge_wr_data[0];
        ADDR_BLEND: m_blend = bridge_wr_data[0];
        ADDR_REGION: m_region = bridge_wr_data[1:0];
        ADDR_IGR: {m_igr_enable, m_igr_combo} = bridge_wr_data[16:0];
        default: ;
      endcase
    end
    m_forced_pal = m_region[0] ? m_region[1] : m_pal;
    if (rtc_time != m_prev_time) begin
      m_flag = ~m_flag;
    end
    m_prev_time = rtc_time;
    m_rtc = {m_flag, 8'h00, 8'h01, rtc_date[23:0], rtc_time[23:0]};
    if (dataslot_requestread || dataslot_requestwrite) begin
      m_save = 1'b1;
    end else if (dataslot_allcomplete && !m_allc_prev) begin
      m_save = 1'b0;
    end
    m_allc_prev = dataslot_allcomplete;
    m_dt_wren = 1'b1;
    m_dt_addr = SAVE_SIZE_SLOT_ADDR;
    m_dt_data = (sram_size == 0) ? 32'd0 : (SAVE_SIZE_BASE << sram_size);
  endtask

  task automatic compare_outputs();
    check_bit("ioctl_download", m_download, ioctl_download);
    check_size("rom_size", m_rom_size, rom_size);
    check_size("ram_size", m_ram_size, ram_size);
    check_data("rom_type", 32'(m_rom_type), 32'(rom_type));
    check_bit("pal", m_pal, pal);
    check_bit("forced_pal", m_forced_pal, forced_pal);
    check_bit("cpu_turbo", m_cpu_turbo, cpu_turbo);
    check_bit("gsu_turbo", m_gsu_turbo, gsu_turbo);
    check_bit("multitap_enabled", m_multitap, multitap_enabled);
    check_bit("lightgun_enabled", m_lightgun, lightgun_enabled);
    check_bit("lightgun_type", m_lightgun_type, lightgun_type);
    check_bit("mouse_enabled", m_mouse, mouse_enabled);
    check_data("dpad_aim_speed", 32'(m_aim_speed), 32'(dpad_aim_speed));
    check_data("joystick_deadzone", 32'(m_deadzone), 32'(joystick_deadzone));
    check_bit("use_square_pixels", m_square_pixels, use_square_pixels);
    check_bit("blend_enabled", m_blend, blend_enabled);
    check_data("core_region", 32'(m_region), 32'(core_region));
    check_bit("igr_enable", m_igr_enable, igr_enable);
    check_key("igr_combo", m_igr_combo, igr_combo);
    check_bit("core_reset", m_core_reset, core_reset);
    check_axis("stick_x", m_stick_x, stick_x);
    check_axis("stick_y", m_stick_y, stick_y);
    check_rtc("rtc_word", m_rtc, rtc_word);
    check_bit("save_download", m_save, save_download);
    check_bit("datatable_wren", m_dt_wren, datatable_wren);
    check_data("datatable_addr", 32'(m_dt_addr), 32'(datatable_addr));
    check_data("datatable_data", m_dt_data, datatable_data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // inputs change 10 ns after the edge, outputs are checked there too
  task automatic step();
    @(posedge clk_74a);
    #10;
    update_model();
    compare_outputs();
  endtask

  task automatic write_reg(input bridge_addr_t addr, input bridge_data_t data);
    bridge_wr = 1'b1;
    bridge_addr = addr;
    bridge_wr_data = data;
    step();
    bridge_wr = 1'b0;
  endtask

  task automatic count_reset_high(input int cycles, output int high);
    high = 0;
    repeat (cycles) begin
      step();
      if (core_reset) begin
        high++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic run_settings();
    int sel;
    test_name = "settings";
    repeat (SETTINGS_CYCLES) begin
      sel = int'($urandom % 20);
      bridge_wr = ($urandom % 4) != 0;
      // 0x400 to 0x7fc holds no register
      bridge_addr = (sel < 15) ? SETTING_ADDRS[sel] : 32'h400 + ($urandom % 256) * 4;
      bridge_wr_data = $urandom;
      step();
    end
    bridge_wr = 1'b0;
  endtask

  task automatic run_host_reset();
    int high;
    test_name = "host_reset";
    write_reg(ADDR_IGR, 32'h0);
    repeat (IGR_HOLD_CYCLES + 2) step();
    write_reg(ADDR_RESET, $urandom);
    count_reset_high(RESET_HOLD_CYCLES + 40, high);
    check_data("hold_length", RESET_HOLD_CYCLES, high);
    write_reg(ADDR_RESET, $urandom);
    repeat (100) step();
    // the second write restarts the full hold
    write_reg(ADDR_RESET, $urandom);
    count_reset_high(RESET_HOLD_CYCLES + 40, high);
    check_data("reload_length", RESET_HOLD_CYCLES, high);
  endtask

  task automatic run_igr();
    key_t combo;
    int   held;
    int   n;
    logic seen;
    test_name = "igr";
    combo = key_t'($urandom);
    cont1_key = ~combo;
    write_reg(ADDR_IGR, {15'h0, 1'b1, combo});
    held = 20 + int'($urandom % 40);
    cont1_key = combo;
    repeat (held) step();
    cont1_key = combo ^ key_t'(1 << ($urandom % 16));
    n = 0;
    do begin
      step();
      n++;
    end while (core_reset && n < IGR_HOLD_CYCLES + 10);
    check_data("release_length", IGR_HOLD_CYCLES, n);
    write_reg(ADDR_IGR, {15'h0, 1'b0, combo});
    cont1_key = combo;
    seen = 1'b0;
    repeat (IGR_OFF_CYCLES) begin
      step();
      seen = seen | core_reset;
    end
    check_bit("disabled_combo", 1'b0, seen);
    cont1_key = '0;
  endtask

  task automatic run_deadzone();
    stick_axis_t x;
    stick_axis_t y;
    int          dz;
    int          dx;
    int          dy;
    test_name = "deadzone";
    repeat (DZ_CYCLES) begin
      bridge_wr = ($urandom % 16) == 0;
      bridge_addr = ADDR_DEADZONE;
      bridge_wr_data = $urandom;
      x = stick_axis_t'($urandom);
      y = stick_axis_t'($urandom);
      // aim a third of the words exactly at the deadzone in effect
      if ($urandom % 3 == 0) begin
        dz = int'(m_deadzone);
        dx = int'($urandom % ((dz < 128) ? dz + 1 : 128));
        dy = dz - dx;
        if (dy <= 128) begin
          x = stick_axis_t'(128 + dx);
          y = stick_axis_t'(128 - dy);
        end
      end
      cont1_joy = {16'($urandom), y, x};
      step();
    end
    bridge_wr = 1'b0;
  endtask

  task automatic run_rtc();
    int sel;
    test_name = "rtc";
    repeat (RTC_CYCLES) begin
      sel = int'($urandom % 8);
      if (sel == 0 || sel == 2) begin
        rtc_time = $urandom;
      end
      if (sel == 1 || sel == 2) begin
        rtc_date = $urandom;
      end
      step();
    end
  endtask

  task automatic run_save_slot();
    test_name = "save_slot";
    repeat (SAVE_CYCLES) begin
      dataslot_requestread = ($urandom % 10) == 0;
      dataslot_requestwrite = ($urandom % 10) == 0;
      if ($urandom % 4 == 0) begin
        dataslot_allcomplete = ~dataslot_allcomplete;
      end
      if ($urandom % 8 == 0) begin
        sram_size = size_code_t'($urandom);
      end
      step();
    end
    dataslot_requestread = 1'b0;
    dataslot_requestwrite = 1'b0;
  endtask

  initial begin
    void'($urandom(23494));
    pll_core_locked = 1'b0;
    bridge_wr = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
    cont1_key = '0;
    cont1_joy = {16'h0, STICK_CENTER, STICK_CENTER};
    rtc_date = '0;
    rtc_time = '0;
    dataslot_requestread = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete = 1'b0;
    sram_size = '0;
    clear_model();
    repeat (16) @(posedge clk_74a);
    #10;
    compare_outputs();
    pll_core_locked = 1'b1;
    run_settings();
    run_host_reset();
    run_igr();
    run_deadzone();
    run_rtc();
    run_save_slot();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+dv
verilog/snes_ctrl_pkg.sv
verilog/settings_regs.sv
verilog/core_reset_gen.sv
verilog/stick_deadzone.sv
verilog/rtc_packer.sv
verilog/save_slot_tracker.sv
verilog/snes_ctrl_top.sv
dv/tb_snes_ctrl.sv
